// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width
`define XLEN 32

// physical register file
`define PRF_NUM 32
`define PRF_W 5

// issue queue entries
`define IQ_DEPTH 8

// micro-ops per dispatch pair
`define DISPATCH_WIDTH 2

`endif

// ==== common/uop_pkg.sv ====
`include "core_settings.svh"

package uop_pkg;

    typedef logic [`PRF_W-1:0] prf_num_t;

    // free entry count, 0 up to IQ_DEPTH
    typedef logic [$clog2(`IQ_DEPTH+1)-1:0] iq_cnt_t;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_sltu = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e          op;
        prf_num_t         dst;
        prf_num_t         src1;
        prf_num_t         src2;
        logic             use_imm;
        logic [`XLEN-1:0] imm;
    } uop_t;

    // sibling flags mark sources written by slot 0 of the same pair
    typedef struct packed {
        logic valid;
        logic src1_sib;
        logic src2_sib;
        uop_t uop;
    } dispatch_slot_t;

    typedef struct packed {
        dispatch_slot_t [`DISPATCH_WIDTH-1:0] slot;
    } dispatch_pair_t;

    typedef struct packed {
        logic valid;
        logic src1_rdy;
        logic src2_rdy;
        uop_t uop;
    } iq_entry_t;

endpackage

// ==== common/wb_pkg.sv ====
`include "core_settings.svh"

package wb_pkg;

    import uop_pkg::*;

    // result bus, doubles as the wakeup broadcast
    typedef struct packed {
        logic             valid;
        prf_num_t         dst;
        logic [`XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } issue_t;

endpackage

// ==== hw/alu_exec.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module alu_exec (
    input  logic           clk,
    input  logic           arst_n,
    input  wb_pkg::issue_t issue,
    output wb_pkg::wb_t    wb
);

    import uop_pkg::*;

    prf_num_t [1:0]          raddr;
    logic [1:0][`XLEN-1:0]   rdata;
    logic [`XLEN-1:0]        op_a;
    logic [`XLEN-1:0]        op_b;
    logic [`XLEN-1:0]        result;
    logic                    wb_vld_q;
    prf_num_t                wb_dst_q;
    logic [`XLEN-1:0]        wb_data_q;

    phys_regfile u_prf (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (raddr),
        .rdata  (rdata),
        .wr     (wb)
    );

    assign raddr[0] = issue.uop.src1;
    assign raddr[1] = issue.uop.src2;

    assign op_a = rdata[0];
    assign op_b = issue.uop.use_imm ? issue.uop.imm : rdata[1];

    always_comb begin
        case (issue.uop.op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_or:   result = op_a | op_b;
            alu_xor:  result = op_a ^ op_b;
            alu_sltu: result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_vld_q <= 1'b0;
        end else begin
            wb_vld_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb_dst_q  <= issue.uop.dst;
            wb_data_q <= result;
        end
    end

    assign wb.valid = wb_vld_q;
    assign wb.dst   = wb_dst_q;
    assign wb.data  = wb_data_q;

endmodule

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module dispatch_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  uop_pkg::dispatch_pair_t pair,
    input  uop_pkg::iq_cnt_t        free_count,
    output logic                    ready,
    output uop_pkg::dispatch_pair_t iq_pair
);

    import uop_pkg::*;

    dispatch_pair_t             packed_pair;
    dispatch_pair_t             pair_q;
    logic [`DISPATCH_WIDTH-1:0] vld_q;
    logic                       accept;

    // room for the pair held here plus one more
    assign ready  = free_count >= iq_cnt_t'(2 * `DISPATCH_WIDTH);
    assign accept = ready && (pair.slot[0].valid || pair.slot[1].valid);

    always_comb begin
        packed_pair = pair;
        // lone slot 1 moves down
        if (!pair.slot[0].valid) begin
            packed_pair.slot[0]       = pair.slot[1];
            packed_pair.slot[1].valid = 1'b0;
        end
        packed_pair.slot[0].src1_sib = 1'b0;
        packed_pair.slot[0].src2_sib = 1'b0;
        packed_pair.slot[1].src1_sib = packed_pair.slot[1].valid &&
            packed_pair.slot[1].uop.src1 == packed_pair.slot[0].uop.dst;
        packed_pair.slot[1].src2_sib = packed_pair.slot[1].valid &&
            !packed_pair.slot[1].uop.use_imm &&
            packed_pair.slot[1].uop.src2 == packed_pair.slot[0].uop.dst;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else if (accept) begin
            vld_q <= {packed_pair.slot[1].valid, packed_pair.slot[0].valid};
        end else begin
            vld_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pair_q <= packed_pair;
        end
    end

    always_comb begin
        iq_pair = pair_q;
        iq_pair.slot[0].valid = vld_q[0];
        iq_pair.slot[1].valid = vld_q[1];
    end

    // the source of micro-ops must hold while the queue is short of room
    a_no_accept_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (pair.slot[0].valid || pair.slot[1].valid) |-> ready)
        else $error("dispatch pair presented while ready is low");

endmodule

// ==== hw/ooo_alu_core.sv ====
`timescale 1ns/1ns

module ooo_alu_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  uop_pkg::dispatch_pair_t pair,
    output logic                    ready,
    output wb_pkg::wb_t             wb
);

    import uop_pkg::*;
    import wb_pkg::*;

    dispatch_pair_t iq_pair;
    iq_cnt_t        free_count;
    issue_t         issue;

    dispatch_stage u_dispatch (
        .clk        (clk),
        .arst_n     (arst_n),
        .pair       (pair),
        .free_count (free_count),
        .ready      (ready),
        .iq_pair    (iq_pair)
    );

    issue_queue u_iq (
        .clk        (clk),
        .arst_n     (arst_n),
        .iq_pair    (iq_pair),
        .wb         (wb),
        .free_count (free_count),
        .issue      (issue)
    );

    // result feeds the queue wakeup and the core output
    alu_exec u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .issue      (issue),
        .wb         (wb)
    );

endmodule

// ==== hw/phys_regfile.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module phys_regfile (
    input  logic                         clk,
    input  logic                         arst_n,
    input  uop_pkg::prf_num_t [1:0]      raddr,
    output logic [1:0][`XLEN-1:0]        rdata,
    input  wb_pkg::wb_t                  wr
);

    logic [`XLEN-1:0] regs_q [`PRF_NUM];

    // all registers start at zero, register 0 included
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PRF_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr.valid) begin
            regs_q[wr.dst] <= wr.data;
        end
    end

    // no bypass, the queue holds consumers until the write has landed
    assign rdata[0] = regs_q[raddr[0]];
    assign rdata[1] = regs_q[raddr[1]];

endmodule

// ==== issue/issue_queue.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module issue_queue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  uop_pkg::dispatch_pair_t iq_pair,
    input  wb_pkg::wb_t             wb,
    output uop_pkg::iq_cnt_t        free_count,
    output wb_pkg::issue_t          issue
);

    import uop_pkg::*;
    import wb_pkg::*;

    localparam int IDX_W = $clog2(`IQ_DEPTH);

    iq_entry_t                        entry_q [`IQ_DEPTH];
    iq_entry_t                        new_entry [`DISPATCH_WIDTH];
    logic [IDX_W-1:0]                 slot_idx [`DISPATCH_WIDTH];
    logic [`DISPATCH_WIDTH-1:0]       slot_ok;
    logic [`DISPATCH_WIDTH-1:0]       pair_vld;
    logic [`DISPATCH_WIDTH-1:0]       set_valid;
    prf_num_t [`DISPATCH_WIDTH-1:0]   set_num;
    prf_num_t [2*`DISPATCH_WIDTH-1:0] rd_num;
    logic [2*`DISPATCH_WIDTH-1:0]     busy;
    logic [`IQ_DEPTH-1:0]             src1_now;
    logic [`IQ_DEPTH-1:0]             src2_now;
    logic [`IQ_DEPTH-1:0]             can_issue;
    logic                             sel_valid;
    logic [IDX_W-1:0]                 sel_idx;
    logic                             issue_vld_q;
    uop_t                             issue_uop_q;

    scoreboard u_sb (
        .clk       (clk),
        .arst_n    (arst_n),
        .set_valid (set_valid),
        .set_num   (set_num),
        .clr       (wb),
        .rd_num    (rd_num),
        .busy      (busy)
    );

    // first free entries, in index order, one per slot
    always_comb begin
        int unsigned n;
        n = 0;
        slot_ok = '0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            slot_idx[k] = '0;
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!entry_q[i].valid) begin
                for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
                    if (n == k) begin
                        slot_idx[k] = IDX_W'(i);
                        slot_ok[k]  = 1'b1;
                    end
                end
                n++;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            pair_vld[k]   = iq_pair.slot[k].valid;
            set_valid[k]  = pair_vld[k] && slot_ok[k];
            set_num[k]    = iq_pair.slot[k].uop.dst;
            rd_num[2*k]   = iq_pair.slot[k].uop.src1;
            rd_num[2*k+1] = iq_pair.slot[k].uop.src2;
            new_entry[k].valid    = 1'b1;
            new_entry[k].uop      = iq_pair.slot[k].uop;
            new_entry[k].src1_rdy = !busy[2*k] && !iq_pair.slot[k].src1_sib;
            new_entry[k].src2_rdy = iq_pair.slot[k].uop.use_imm ||
                (!busy[2*k+1] && !iq_pair.slot[k].src2_sib);
        end
    end

    // wakeup from this cycle's writeback counts for select
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            src1_now[i]  = entry_q[i].src1_rdy ||
                (wb.valid && wb.dst == entry_q[i].uop.src1);
            src2_now[i]  = entry_q[i].src2_rdy ||
                (wb.valid && wb.dst == entry_q[i].uop.src2);
            can_issue[i] = entry_q[i].valid && src1_now[i] && src2_now[i];
        end
    end

    // lowest index wins
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (can_issue[i]) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        free_count = iq_cnt_t'(`IQ_DEPTH);
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (entry_q[i].valid) begin
                free_count = free_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                entry_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                entry_q[i].src1_rdy <= src1_now[i];
                entry_q[i].src2_rdy <= src2_now[i];
            end
            if (sel_valid) begin
                entry_q[sel_idx].valid <= 1'b0;
            end
            for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
                if (set_valid[k]) begin
                    entry_q[slot_idx[k]] <= new_entry[k];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_vld_q <= 1'b0;
        end else begin
            issue_vld_q <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            issue_uop_q <= entry_q[sel_idx].uop;
        end
    end

    assign issue.valid = issue_vld_q;
    assign issue.uop   = issue_uop_q;

    // dispatch back-pressure must leave a free entry for every slot
    a_enq_fits: assert property (@(posedge clk) disable iff (!arst_n)
        (pair_vld & ~slot_ok) == '0)
        else $error("enqueue with no free entry");

    // a source still on the writeback bus has not reached the register file
    a_issue_src_ready: assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid && wb.valid |-> wb.dst != issue.uop.src1 &&
            (issue.uop.use_imm || wb.dst != issue.uop.src2))
        else $error("issued micro-op reads register %0d before writeback", wb.dst);

endmodule

// ==== issue/scoreboard.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module scoreboard (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic [`DISPATCH_WIDTH-1:0]                set_valid,
    input  uop_pkg::prf_num_t [`DISPATCH_WIDTH-1:0]   set_num,
    input  wb_pkg::wb_t                               clr,
    input  uop_pkg::prf_num_t [2*`DISPATCH_WIDTH-1:0] rd_num,
    output logic [2*`DISPATCH_WIDTH-1:0]              busy
);

    // one bit per physical register, high while a write is pending
    logic [`PRF_NUM-1:0] busy_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            if (clr.valid) begin
                busy_q[clr.dst] <= 1'b0;
            end
            for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
                if (set_valid[k]) begin
                    busy_q[set_num[k]] <= 1'b1;
                end
            end
        end
    end

    // same-cycle clear reads as not busy
    always_comb begin
        for (int i = 0; i < 2 * `DISPATCH_WIDTH; i++) begin
            busy[i] = busy_q[rd_num[i]] && !(clr.valid && clr.dst == rd_num[i]);
        end
    end

    // every writeback must match an earlier enqueue of its destination
    a_clr_was_busy: assert property (@(posedge clk) disable iff (!arst_n)
        clr.valid |-> busy_q[clr.dst])
        else $error("writeback to register %0d with no pending write", clr.dst);

endmodule

// ==== ooo_alu_core.f ====
+incdir+common
common/uop_pkg.sv
common/wb_pkg.sv
hw/dispatch_stage.sv
issue/scoreboard.sv
issue/issue_queue.sv
hw/phys_regfile.sv
hw/alu_exec.sv
hw/ooo_alu_core.sv
tests/tb_ooo_alu_core.sv

// ==== tests/tb_ooo_alu_core.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_ooo_alu_core;

    import uop_pkg::*;
    import wb_pkg::*;

    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 200;

    typedef struct {
        int             test;
        dispatch_pair_t pair;
    } prog_row_t;

    logic           clk;
    logic           arst_n;
    dispatch_pair_t pair;
    logic           ready;
    wb_t            wb;

    prog_row_t        prog [$];
    logic [`XLEN-1:0] model_regs [`PRF_NUM];
    logic [`XLEN-1:0] exp_data [`PRF_NUM];
    bit               exp_pending [`PRF_NUM];
    int               outstanding;
    int               checks;
    int               errors;
    int               stalls;
    bit               timed_out;
    integer           seed;

    ooo_alu_core dut (
        .clk    (clk),
        .arst_n (arst_n),
        .pair   (pair),
        .ready  (ready),
        .wb     (wb)
    );

    always #10 clk = ~clk;

    function automatic uop_t make_uop(input alu_op_e op, input int dst, input int s1,
                                      input int s2, input bit use_imm,
                                      input logic [`XLEN-1:0] imm);
        uop_t u;
        u.op      = op;
        u.dst     = prf_num_t'(dst);
        u.src1    = prf_num_t'(s1);
        u.src2    = prf_num_t'(s2);
        u.use_imm = use_imm;
        u.imm     = imm;
        return u;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input alu_op_e op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sltu: return (a < b) ? `XLEN'd1 : `XLEN'd0;
            default:  return '0;
        endcase
    endfunction

    task automatic add_pair(input int test, input bit v0, input uop_t u0,
                            input bit v1, input uop_t u1);
        prog_row_t row;
        row.test               = test;
        row.pair               = '0;
        row.pair.slot[0].valid = v0;
        row.pair.slot[0].uop   = u0;
        row.pair.slot[1].valid = v1;
        row.pair.slot[1].uop   = u1;
        prog.push_back(row);
    endtask

    task automatic check_value(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic build_fixed_rows();
        // independent immediates, one lone slot 0 and one lone slot 1
        add_pair(2, 1, make_uop(alu_add, 1, 0, 0, 1, 32'h11),
                    1, make_uop(alu_add, 2, 0, 0, 1, 32'hdeadbeef));
        add_pair(2, 1, make_uop(alu_add, 3, 0, 0, 1, 32'h7fffffff),
                    1, make_uop(alu_add, 4, 0, 0, 1, 32'h0));
        add_pair(2, 0, '0, 1, make_uop(alu_add, 5, 0, 0, 1, 32'h12345678));
        add_pair(2, 1, make_uop(alu_add, 6, 0, 0, 1, 32'hffffffff), 0, '0);
        // dependent chains, slot 1 often reads slot 0
        add_pair(3, 1, make_uop(alu_add, 7, 1, 2, 0, 0),
                    1, make_uop(alu_sub, 8, 7, 3, 0, 0));
        add_pair(3, 1, make_uop(alu_and, 9, 8, 2, 0, 0),
                    1, make_uop(alu_or, 10, 9, 0, 1, 32'h0f0f0000));
        add_pair(3, 1, make_uop(alu_xor, 11, 10, 8, 0, 0),
                    1, make_uop(alu_sltu, 12, 3, 11, 0, 0));
        add_pair(3, 1, make_uop(alu_sltu, 13, 11, 0, 1, 32'h1000),
                    1, make_uop(alu_sub, 14, 13, 12, 0, 0));
        add_pair(3, 0, '0, 1, make_uop(alu_xor, 15, 14, 7, 0, 0));
        // long chain first, then independent work behind it
        for (int i = 0; i < 5; i++) begin
            add_pair(4, 1, make_uop(alu_add, 16 + 2 * i, 15 + 2 * i, 0, 1, 2 * i + 1),
                        1, make_uop(alu_sub, 17 + 2 * i, 16 + 2 * i, 0, 1, 32'h3));
        end
        for (int i = 0; i < 6; i++) begin
            add_pair(4, 1, make_uop(alu_or, 26 + i, 0, 0, 1, 32'h100 * (26 + i)),
                        1, make_uop(alu_or, 1 + i, 0, 0, 1, 32'h5a000 + i));
        end
    endtask

    task automatic build_random_rows();
        prf_num_t written [$];
        uop_t     u [2];
        int       dst;
        int       op_i;
        int       s1;
        int       s2;
        dst = 1;
        for (int p = 0; p < 8; p++) begin
            for (int k = 0; k < 2; k++) begin
                if (written.size() < 2) begin
                    u[k] = make_uop(alu_add, dst, 0, 0, 1, $random(seed));
                end else begin
                    op_i = $unsigned($random(seed)) % 6;
                    s1   = written[$unsigned($random(seed)) % written.size()];
                    s2   = written[$unsigned($random(seed)) % written.size()];
                    u[k] = make_uop(alu_op_e'(op_i), dst, s1, s2, $random(seed) & 1,
                                    $random(seed));
                end
                written.push_back(prf_num_t'(dst));
                dst++;
            end
            add_pair(5, 1'b1, u[0], 1'b1, u[1]);
        end
    endtask

    // program order over this test's rows
    task automatic run_model(input int test);
        uop_t             u;
        logic [`XLEN-1:0] b;
        for (int r = 0; r < prog.size(); r++) begin
            for (int k = 0; k < 2; k++) begin
                if (prog[r].test == test && prog[r].pair.slot[k].valid) begin
                    u = prog[r].pair.slot[k].uop;
                    b = u.use_imm ? u.imm : model_regs[u.src2];
                    model_regs[u.dst]  = alu_model(u.op, model_regs[u.src1], b);
                    exp_data[u.dst]    = model_regs[u.dst];
                    exp_pending[u.dst] = 1'b1;
                    outstanding++;
                end
            end
        end
    endtask

    task automatic send_pair(input int r);
        int waited;
        waited = 0;
        while (!ready && waited < WAIT_LIMIT) begin
            pair = '0;
            @(negedge clk);
            waited++;
        end
        if (waited > 0) begin
            stalls++;
        end
        if (!ready) begin
            $display("timeout: ready stayed low for %0d cycles in test %0d",
                     WAIT_LIMIT, prog[r].test);
            timed_out = 1'b1;
            pair = '0;
        end else begin
            pair = prog[r].pair;
            @(negedge clk);
        end
    endtask

    task automatic wait_drain(input int test);
        int waited;
        waited = 0;
        while (outstanding > 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (outstanding > 0) begin
            $display("timeout: %0d writebacks still missing in test %0d", outstanding, test);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_idle();
        check_value(ready, 1'b1, "ready after reset");
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value(wb.valid, 1'b0, "wb valid with no input");
        end
    endtask

    // wb is stable away from the rising edge
    always @(negedge clk) begin
        if (arst_n && wb.valid) begin
            if (!exp_pending[wb.dst]) begin
                errors++;
                $display("unexpected writeback to register %0d at %0t ns", wb.dst, $time);
            end else begin
                check_value(wb.data, exp_data[wb.dst], $sformatf("register %0d", wb.dst));
                exp_pending[wb.dst] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        int chk_before;
        int err_before;
        clk         = 1'b0;
        arst_n      = 1'b0;
        pair        = '0;
        seed        = 7618;
        outstanding = 0;
        checks      = 0;
        errors      = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < `PRF_NUM; i++) begin
            model_regs[i]  = '0;
            exp_data[i]    = '0;
            exp_pending[i] = 1'b0;
        end
        build_fixed_rows();
        build_random_rows();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (!timed_out) begin
                chk_before = checks;
                err_before = errors;
                stalls     = 0;
                if (t == 1) begin
                    check_idle();
                end else begin
                    run_model(t);
                    for (int r = 0; r < prog.size(); r++) begin
                        if (prog[r].test == t && !timed_out) begin
                            send_pair(r);
                        end
                    end
                    pair = '0;
                    wait_drain(t);
                    if (t == 4) begin
                        check_value(stalls > 0, 1'b1, "ready went low under back-pressure");
                    end
                    // idle gap catches a duplicate writeback
                    repeat (4) @(negedge clk);
                end
                $display("test %0d finished: %0d checks, %0d errors", t,
                         checks - chk_before, errors - err_before);
            end
        end
        $display("all tests: %0d checks, %0d errors, %0d timeouts", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
